/* cpu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic                CLOCK,
  input  logic                RESET,
  input  logic [`REGSIZE-1:0] read_bus,
  output mem_ctrl_t           ctrl_bus,
  output logic [`REGSIZE-1:0] addr_bus,
  output logic [`REGSIZE-1:0] write_bus,
  output logic [`REGSIZE-1:0] out,
  output logic [`REGSIZE-1:0] flags
);

  stage_t              stage;
  logic                fetch_done;
  logic                operand_done;
  logic                write_done;
  logic                ip_step;
  logic [`REGSIZE-1:0] ip;
  logic [`REGSIZE-1:0] operand_addr;
  logic [`REGSIZE-1:0] write_addr;
  logic [`REGSIZE-1:0] jmp_offset;
  opcode_t             decode_ope;
  operand_t            decode_src;
  operand_t            decode_dst;

  operand_if opnd ();

  stage_sequencer sequencer0 (
    .CLOCK        (CLOCK),
    .RESET        (RESET),
    .fetch_done   (fetch_done),
    .operand_done (operand_done),
    .write_done   (write_done),
    .decode_dst   (decode_dst),
    .ip           (ip),
    .operand_addr (operand_addr),
    .write_addr   (write_addr),
    .stage        (stage),
    .ctrl_bus     (ctrl_bus),
    .addr_bus     (addr_bus)
  );

  instruction_fetch fetch0 (
    .CLOCK      (CLOCK),
    .RESET      (RESET),
    .stage      (stage),
    .read_bus   (read_bus),
    .jmp_offset (jmp_offset),
    .ip_step    (ip_step),
    .ip         (ip),
    .fetch_done (fetch_done),
    .decode_ope (decode_ope),
    .decode_src (decode_src),
    .decode_dst (decode_dst)
  );

  operand_fetch operand0 (
    .CLOCK        (CLOCK),
    .RESET        (RESET),
    .stage        (stage),
    .read_bus     (read_bus),
    .decode_src   (decode_src),
    .decode_dst   (decode_dst),
    .ip           (ip),
    .operand_done (operand_done),
    .ip_step      (ip_step),
    .operand_addr (operand_addr),
    .opnd         (opnd.fetch)
  );

  execute_unit execute0 (
    .CLOCK      (CLOCK),
    .RESET      (RESET),
    .stage      (stage),
    .decode_ope (decode_ope),
    .decode_src (decode_src),
    .decode_dst (decode_dst),
    .opnd       (opnd.exec),
    .jmp_offset (jmp_offset),
    .write_done (write_done),
    .write_addr (write_addr),
    .write_bus  (write_bus),
    .out        (out),
    .flags      (flags)
  );

endmodule

`default_nettype wire

/* cpu_ctrl_pkg.sv */
`default_nettype none

package cpu_ctrl_pkg;

  typedef enum logic [2:0] {
    RESET_STAGE,
    FETCH_OPERATION,
    DECODE,
    FETCH_IMMEDIATE,
    EXECUTE,
    WRITE_REGISTER,
    WRITE_MEMORY
  } stage_t;

  // Opcode fetch and memory write
  typedef enum logic [1:0] {
    IDL,
    BGN,
    END
  } phase_t;

  // Operand fetch with one WAIT and LOAD pair per byte
  typedef enum logic [3:0] {
    IMM_IDL,
    IMM_BGN,
    WAIT_IMMEDIATE,
    LOAD_IMMEDIATE,
    WAIT_SRC_ADDR,
    LOAD_SRC_ADDR,
    WAIT_SRC,
    LOAD_SRC,
    WAIT_DST_ADDR,
    LOAD_DST_ADDR,
    WAIT_DST,
    LOAD_DST,
    IMM_END
  } imm_phase_t;

  typedef enum logic [1:0] {
    STAY,
    READ,
    WRITE
  } mem_ctrl_t;

endpackage

`default_nettype wire

/* cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

  // Decoded instruction
  typedef enum logic [2:0] {
    MOV,
    ADD,
    CMP,
    JMP,
    NOP,
    HLT
  } opcode_t;

  // Decoded operand kind
  // IMM is only legal as a source
  typedef enum logic [2:0] {
    UNUSED,
    REG_A,
    REG_SP,
    IMM,
    ADDRESS_IMM
  } operand_t;

endpackage

`default_nettype wire

/* cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data path widths
`define REGSIZE        8
`define EXTEND_REGSIZE 9

// Bit positions in FLAG
`define FLAG_CARRY     0
`define FLAG_ZERO      1
`define FLAG_SIGN      2
`define FLAG_OVERFLOW  3
`define FLAG_UNDERFLOW 4

// Addressable bytes on the memory bus
`define MEMSIZE 256

`endif

/* execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module execute_unit
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic                CLOCK,
  input  logic                RESET,
  input  stage_t              stage,
  input  opcode_t             decode_ope,
  input  operand_t            decode_src,
  input  operand_t            decode_dst,
  operand_if.exec             opnd,
  output logic [`REGSIZE-1:0] jmp_offset,
  output logic                write_done,
  output logic [`REGSIZE-1:0] write_addr,
  output logic [`REGSIZE-1:0] write_bus,
  output logic [`REGSIZE-1:0] out,
  output logic [`REGSIZE-1:0] flags
);

  logic [`REGSIZE-1:0]        reg_a;
  logic [`REGSIZE-1:0]        reg_sp;
  logic [`REGSIZE-1:0]        reg_flag;
  logic [`REGSIZE-1:0]        src;
  logic [`REGSIZE-1:0]        old_dst;
  logic [`REGSIZE-1:0]        result;
  logic [`REGSIZE-1:0]        pend_flag;
  logic [`REGSIZE-1:0]        alu_flag;
  logic [`EXTEND_REGSIZE-1:0] neg_src;
  logic [`EXTEND_REGSIZE-1:0] alu_out;
  phase_t                     wr_phase;
  phase_t                     next_wr_phase;

  always_comb begin
    case (decode_src)
      REG_A:       src = reg_a;
      REG_SP:      src = reg_sp;
      IMM:         src = opnd.imm;
      ADDRESS_IMM: src = opnd.mem_src;
      default:     src = '0;
    endcase
    case (decode_dst)
      REG_A:       old_dst = reg_a;
      REG_SP:      old_dst = reg_sp;
      ADDRESS_IMM: old_dst = opnd.mem_dst;
      default:     old_dst = '0;
    endcase
  end

  assign neg_src = ~{1'b0, src} + `EXTEND_REGSIZE'd1;

  always_comb begin
    case (decode_ope)
      ADD:     alu_out = {1'b0, old_dst} + {1'b0, src};
      CMP:     alu_out = {1'b0, old_dst} + neg_src;
      MOV:     alu_out = {1'b0, src};
      default: alu_out = {1'b0, old_dst};
    endcase
  end

  always_comb begin
    alu_flag                  = '0;
    alu_flag[`FLAG_CARRY]     = alu_out[`EXTEND_REGSIZE-1];
    alu_flag[`FLAG_ZERO]      = (alu_out[`REGSIZE-1:0] == '0);
    alu_flag[`FLAG_SIGN]      = alu_out[`REGSIZE-1];
    alu_flag[`FLAG_OVERFLOW]  = ~alu_out[`EXTEND_REGSIZE-1] & alu_out[`REGSIZE-1];
    alu_flag[`FLAG_UNDERFLOW] = alu_out[`EXTEND_REGSIZE-1] & ~alu_out[`REGSIZE-1];
  end

  always_comb begin
    next_wr_phase = IDL;
    if (stage == WRITE_MEMORY) begin
      case (wr_phase)
        IDL:     next_wr_phase = BGN;
        BGN:     next_wr_phase = END;
        default: next_wr_phase = IDL;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      reg_a     <= '0;
      reg_sp    <= '0;
      reg_flag  <= '0;
      result    <= '0;
      pend_flag <= '0;
      wr_phase  <= IDL;
    end else begin
      wr_phase <= next_wr_phase;
      if (stage == EXECUTE) begin
        // CMP writes back the old destination unchanged
        result <= (decode_ope == CMP) ? old_dst : alu_out[`REGSIZE-1:0];
        if (decode_ope == ADD || decode_ope == CMP) begin
          pend_flag <= alu_flag;
        end
      end
      if (stage == WRITE_REGISTER) begin
        reg_flag <= pend_flag;
        if (decode_dst == REG_A) begin
          reg_a <= result;
        end
        if (decode_dst == REG_SP) begin
          reg_sp <= result;
        end
      end
    end
  end

  assign jmp_offset = (decode_ope == JMP) ? opnd.imm : '0;
  assign write_done = (wr_phase == END);
  assign write_addr = opnd.dst_addr;
  assign write_bus  = result;
  assign out        = reg_a;
  assign flags      = reg_flag;

endmodule

`default_nettype wire

/* instruction_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module instruction_fetch
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic                CLOCK,
  input  logic                RESET,
  input  stage_t              stage,
  input  logic [`REGSIZE-1:0] read_bus,
  input  logic [`REGSIZE-1:0] jmp_offset,
  input  logic                ip_step,
  output logic [`REGSIZE-1:0] ip,
  output logic                fetch_done,
  output opcode_t             decode_ope,
  output operand_t            decode_src,
  output operand_t            decode_dst
);

  localparam logic [`REGSIZE-1:0] NOP_BYTE = 8'b11_111_110;
  localparam logic [`REGSIZE-1:0] JMP_BYTE = 8'b11_010_000;

  phase_t              phase;
  phase_t              next_phase;
  logic [`REGSIZE-1:0] ope;
  logic [`REGSIZE-1:0] next_ip;
  operand_t            src_kind;
  operand_t            dst_kind;
  opcode_t             next_ope;
  operand_t            next_src;
  operand_t            next_dst;

  // UNUSED marks the register-indirect codes
  function automatic operand_t field_operand(input logic [2:0] field);
    operand_t kind;
    case (field)
      3'b000:         kind = REG_A;
      3'b100:         kind = REG_SP;
      3'b010, 3'b110: kind = ADDRESS_IMM;
      3'b011, 3'b111: kind = IMM;
      default:        kind = UNUSED;
    endcase
    return kind;
  endfunction

  always_comb begin
    next_phase = IDL;
    if (stage == FETCH_OPERATION) begin
      case (phase)
        IDL:     next_phase = BGN;
        BGN:     next_phase = END;
        default: next_phase = IDL;
      endcase
    end
  end

  assign fetch_done = (phase == END);

  // Halted core keeps its ip
  always_comb begin
    next_ip = ip;
    if (decode_ope != HLT) begin
      if (phase == END || ip_step) begin
        next_ip = ip + `REGSIZE'd1;
      end else if (stage == EXECUTE && decode_ope == JMP) begin
        next_ip = ip + jmp_offset;
      end
    end
  end

  // HLT is sticky until reset
  always_comb begin
    src_kind = field_operand(ope[2:0]);
    dst_kind = field_operand(ope[5:3]);
    next_ope = decode_ope;
    next_src = decode_src;
    next_dst = decode_dst;
    if (stage == DECODE && decode_ope != HLT) begin
      next_ope = HLT;
      next_src = UNUSED;
      next_dst = UNUSED;
      if (ope[7:6] != 2'b11) begin
        if (src_kind != UNUSED && dst_kind != UNUSED && dst_kind != IMM) begin
          next_src = src_kind;
          next_dst = dst_kind;
          case (ope[7:6])
            2'b00:   next_ope = MOV;
            2'b01:   next_ope = ADD;
            default: next_ope = CMP;
          endcase
        end
      end else if (ope == JMP_BYTE) begin
        next_ope = JMP;
        next_src = IMM;
      end else if (ope == NOP_BYTE) begin
        next_ope = NOP;
      end
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      phase      <= IDL;
      ip         <= '0;
      ope        <= NOP_BYTE;
      decode_ope <= NOP;
      decode_src <= UNUSED;
      decode_dst <= UNUSED;
    end else begin
      phase      <= next_phase;
      ip         <= next_ip;
      decode_ope <= next_ope;
      decode_src <= next_src;
      decode_dst <= next_dst;
      if (phase == BGN) begin
        ope <= read_bus;
      end
    end
  end

endmodule

`default_nettype wire

/* operand_fetch.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module operand_fetch
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic                CLOCK,
  input  logic                RESET,
  input  stage_t              stage,
  input  logic [`REGSIZE-1:0] read_bus,
  input  operand_t            decode_src,
  input  operand_t            decode_dst,
  input  logic [`REGSIZE-1:0] ip,
  output logic                operand_done,
  output logic                ip_step,
  output logic [`REGSIZE-1:0] operand_addr,
  operand_if.fetch            opnd
);

  imm_phase_t          phase;
  imm_phase_t          next_phase;
  imm_phase_t          dst_step;
  logic [`REGSIZE-1:0] src_addr;

  always_comb begin
    // Destination items come after all source items
    dst_step   = (decode_dst == ADDRESS_IMM) ? WAIT_DST_ADDR : IMM_END;
    next_phase = IMM_IDL;
    if (stage == FETCH_IMMEDIATE) begin
      case (phase)
        IMM_IDL: next_phase = IMM_BGN;
        IMM_BGN: begin
          if (decode_src == IMM) begin
            next_phase = WAIT_IMMEDIATE;
          end else if (decode_src == ADDRESS_IMM) begin
            next_phase = WAIT_SRC_ADDR;
          end else begin
            next_phase = dst_step;
          end
        end
        WAIT_IMMEDIATE: next_phase = LOAD_IMMEDIATE;
        LOAD_IMMEDIATE: next_phase = dst_step;
        WAIT_SRC_ADDR:  next_phase = LOAD_SRC_ADDR;
        LOAD_SRC_ADDR:  next_phase = WAIT_SRC;
        WAIT_SRC:       next_phase = LOAD_SRC;
        LOAD_SRC:       next_phase = dst_step;
        WAIT_DST_ADDR:  next_phase = LOAD_DST_ADDR;
        LOAD_DST_ADDR:  next_phase = WAIT_DST;
        WAIT_DST:       next_phase = LOAD_DST;
        LOAD_DST:       next_phase = IMM_END;
        default:        next_phase = IMM_IDL;
      endcase
    end
  end

  assign operand_done = (phase == IMM_END);

  // Bytes from the instruction stream advance ip once loaded
  always_comb begin
    ip_step      = 1'b0;
    operand_addr = '0;
    case (phase)
      WAIT_IMMEDIATE, WAIT_SRC_ADDR, WAIT_DST_ADDR: begin
        operand_addr = ip;
      end
      LOAD_IMMEDIATE, LOAD_SRC_ADDR, LOAD_DST_ADDR: begin
        operand_addr = ip;
        ip_step      = 1'b1;
      end
      WAIT_SRC, LOAD_SRC: operand_addr = src_addr;
      WAIT_DST, LOAD_DST: operand_addr = opnd.dst_addr;
      default:            operand_addr = '0;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      phase <= IMM_IDL;
    end else begin
      phase <= next_phase;
    end
  end

  always_ff @(posedge CLOCK) begin
    case (phase)
      LOAD_IMMEDIATE: opnd.imm      <= read_bus;
      LOAD_SRC_ADDR:  src_addr      <= read_bus;
      LOAD_SRC:       opnd.mem_src  <= read_bus;
      LOAD_DST_ADDR:  opnd.dst_addr <= read_bus;
      LOAD_DST:       opnd.mem_dst  <= read_bus;
      default:        src_addr      <= src_addr;
    endcase
  end

  a_done_in_fetch_immediate: assert property (
    @(posedge CLOCK) disable iff (RESET)
    operand_done |-> stage == FETCH_IMMEDIATE
  ) else $error("operand_done outside FETCH_IMMEDIATE");

endmodule

`default_nettype wire

/* operand_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

interface operand_if;
  logic [`REGSIZE-1:0] imm;
  logic [`REGSIZE-1:0] mem_src;
  logic [`REGSIZE-1:0] mem_dst;
  logic [`REGSIZE-1:0] dst_addr;

  modport fetch (
    output imm,
    output mem_src,
    output mem_dst,
    output dst_addr
  );

  modport exec (
    input imm,
    input mem_src,
    input mem_dst,
    input dst_addr
  );
endinterface

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the CPU testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_cpu -o sim_tb_cpu > build.log 2>&1 \
  && ./obj_dir/sim_tb_cpu 2>&1 | tee sim.log \
  && grep -q "test passed" sim.log \
  && ! grep -q "test failed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* stage_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module stage_sequencer
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic                CLOCK,
  input  logic                RESET,
  input  logic                fetch_done,
  input  logic                operand_done,
  input  logic                write_done,
  input  operand_t            decode_dst,
  input  logic [`REGSIZE-1:0] ip,
  input  logic [`REGSIZE-1:0] operand_addr,
  input  logic [`REGSIZE-1:0] write_addr,
  output stage_t              stage,
  output mem_ctrl_t           ctrl_bus,
  output logic [`REGSIZE-1:0] addr_bus
);

  stage_t next_stage;
  logic   in_write_memory;

  always_comb begin
    case (stage)
      RESET_STAGE:     next_stage = FETCH_OPERATION;
      FETCH_OPERATION: next_stage = fetch_done ? DECODE : FETCH_OPERATION;
      DECODE:          next_stage = FETCH_IMMEDIATE;
      FETCH_IMMEDIATE: next_stage = operand_done ? EXECUTE : FETCH_IMMEDIATE;
      EXECUTE:         next_stage = WRITE_REGISTER;
      WRITE_REGISTER:  next_stage = (decode_dst == ADDRESS_IMM) ? WRITE_MEMORY : FETCH_OPERATION;
      WRITE_MEMORY:    next_stage = write_done ? FETCH_OPERATION : WRITE_MEMORY;
      default:         next_stage = FETCH_OPERATION;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage           <= RESET_STAGE;
      in_write_memory <= 1'b0;
    end else begin
      stage           <= next_stage;
      in_write_memory <= (stage == WRITE_MEMORY);
    end
  end

  // Write strobe skips the idle first cycle of the write stage
  always_comb begin
    case (stage)
      FETCH_OPERATION: begin
        ctrl_bus = READ;
        addr_bus = ip;
      end
      FETCH_IMMEDIATE: begin
        ctrl_bus = READ;
        addr_bus = operand_addr;
      end
      WRITE_MEMORY: begin
        ctrl_bus = in_write_memory ? WRITE : STAY;
        addr_bus = write_addr;
      end
      default: begin
        ctrl_bus = STAY;
        addr_bus = '0;
      end
    endcase
  end

  a_write_to_memory_operand: assert property (
    @(posedge CLOCK) disable iff (RESET)
    ctrl_bus == WRITE |-> stage == WRITE_MEMORY && decode_dst == ADDRESS_IMM
  ) else $error("memory write without a memory destination");

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
operand_if.sv
stage_sequencer.sv
instruction_fetch.sv
operand_fetch.sv
execute_unit.sv
cpu.sv
tb_cpu.sv

/* tb_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module tb_cpu
  import cpu_ctrl_pkg::*;
();

  localparam int RESET_CYCLES      = 8;
  localparam int MAX_INSTRUCTIONS  = 30;
  localparam int MAX_INSTR_CYCLES  = 16;
  localparam int HALT_ENTRY_CYCLES = 20;
  localparam int HALT_HOLD_CYCLES  = 100;
  localparam int TIMEOUT_CYCLES    = 2 * (RESET_CYCLES + MAX_INSTRUCTIONS * MAX_INSTR_CYCLES +
                                          HALT_ENTRY_CYCLES + HALT_HOLD_CYCLES);

  // Opcode bytes laid out as class then dst field then src field
  localparam logic [7:0] OP_MOV_A_IMM = 8'b00_000_011;
  localparam logic [7:0] OP_ADD_A_IMM = 8'b01_000_011;
  localparam logic [7:0] OP_CMP_A_IMM = 8'b10_000_011;
  localparam logic [7:0] OP_MOV_MEM_A = 8'b00_010_000;
  localparam logic [7:0] OP_ADD_A_MEM = 8'b01_000_010;
  localparam logic [7:0] OP_MOV_SP_A  = 8'b00_100_000;
  localparam logic [7:0] OP_MOV_A_SP  = 8'b00_000_100;
  localparam logic [7:0] OP_JMP       = 8'b11_010_000;
  localparam logic [7:0] OP_NOP       = 8'b11_111_110;
  localparam logic [7:0] OP_HLT       = 8'b11_111_111;
  localparam logic [7:0] SKIPPED_VALUE = 8'hEE;

  logic                CLOCK;
  logic                RESET;
  logic [`REGSIZE-1:0] read_bus;
  mem_ctrl_t           ctrl_bus;
  logic [`REGSIZE-1:0] addr_bus;
  logic [`REGSIZE-1:0] write_bus;
  logic [`REGSIZE-1:0] out;
  logic [`REGSIZE-1:0] flags;

  logic [7:0] mem [0:`MEMSIZE-1];
  logic       exp_valid [0:`MEMSIZE-1];
  logic [7:0] exp_data [0:`MEMSIZE-1];
  logic [7:0] exp_flags [0:`MEMSIZE-1];
  logic [7:0] prog_pc;
  logic [7:0] model_a;
  logic [7:0] model_sp;
  logic [7:0] model_flags;
  int         exp_store_count;
  int         store_count;
  int         cycle = 0;
  logic       halt_window;

  cpu dut0 (
    .CLOCK     (CLOCK),
    .RESET     (RESET),
    .read_bus  (read_bus),
    .ctrl_bus  (ctrl_bus),
    .addr_bus  (addr_bus),
    .write_bus (write_bus),
    .out       (out),
    .flags     (flags)
  );

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] want);
    $display("MISMATCH %s got %02h expected %02h", name, got, want);
    abort_run();
  endtask

  task automatic report_error(input string what);
    $display("ERROR %s", what);
    abort_run();
  endtask

  // Carry, zero, sign, overflow and underflow of a 9-bit ALU result
  function automatic logic [7:0] flag_rule(input logic [8:0] r);
    logic [7:0] f;
    f                  = '0;
    f[`FLAG_CARRY]     = r[8];
    f[`FLAG_ZERO]      = (r[7:0] == 8'h00);
    f[`FLAG_SIGN]      = r[7];
    f[`FLAG_OVERFLOW]  = !r[8] && r[7];
    f[`FLAG_UNDERFLOW] = r[8] && !r[7];
    return f;
  endfunction

  task automatic put_byte(input logic [7:0] b);
    mem[prog_pc] = b;
    prog_pc      = prog_pc + 8'd1;
  endtask

  task automatic mov_a_imm(input logic [7:0] v);
    put_byte(OP_MOV_A_IMM);
    put_byte(v);
    model_a = v;
  endtask

  task automatic add_a_imm(input logic [7:0] v);
    logic [8:0] sum;
    sum = {1'b0, model_a} + {1'b0, v};
    put_byte(OP_ADD_A_IMM);
    put_byte(v);
    model_flags = flag_rule(sum);
    model_a     = sum[7:0];
  endtask

  // Only the flags follow A minus v
  task automatic cmp_a_imm(input logic [7:0] v);
    logic [8:0] diff;
    diff = {1'b0, model_a} - {1'b0, v};
    put_byte(OP_CMP_A_IMM);
    put_byte(v);
    model_flags = flag_rule(diff);
  endtask

  // Source byte is whatever an earlier store put there
  task automatic add_a_mem(input logic [7:0] addr);
    logic [8:0] sum;
    sum = {1'b0, model_a} + {1'b0, exp_data[addr]};
    put_byte(OP_ADD_A_MEM);
    put_byte(addr);
    model_flags = flag_rule(sum);
    model_a     = sum[7:0];
  endtask

  task automatic store_a(input logic [7:0] addr);
    put_byte(OP_MOV_MEM_A);
    put_byte(addr);
    exp_valid[addr] = 1'b1;
    exp_data[addr]  = model_a;
    exp_flags[addr] = model_flags;
    exp_store_count++;
  endtask

  task automatic load_program();
    prog_pc         = 8'h00;
    model_a         = 8'h00;
    model_sp        = 8'h00;
    model_flags     = 8'h00;
    exp_store_count = 0;
    for (int i = 0; i < `MEMSIZE; i++) begin
      mem[8'(i)]       = 8'(i) ^ 8'hA5;
      exp_valid[8'(i)] = 1'b0;
      exp_data[8'(i)]  = 8'h00;
      exp_flags[8'(i)] = 8'h00;
    end
    mov_a_imm(8'h3C);
    store_a(8'hF0);
    // Carry out with underflow
    add_a_imm(8'hD9);
    store_a(8'hF1);
    // Overflow into bit 7
    mov_a_imm(8'h50);
    add_a_imm(8'h40);
    store_a(8'hF2);
    add_a_imm(8'h70);
    store_a(8'hF3);
    mov_a_imm(8'h22);
    cmp_a_imm(8'h35);
    store_a(8'hF4);
    cmp_a_imm(8'h22);
    store_a(8'hF5);
    store_a(8'h40);
    mov_a_imm(8'h19);
    add_a_mem(8'h40);
    store_a(8'hF6);
    put_byte(OP_MOV_SP_A);
    model_sp = model_a;
    mov_a_imm(8'h00);
    put_byte(OP_MOV_A_SP);
    model_a = model_sp;
    store_a(8'hF7);
    // Relative jump over a MOV that must never run
    put_byte(OP_JMP);
    put_byte(8'h02);
    put_byte(OP_MOV_A_IMM);
    put_byte(SKIPPED_VALUE);
    store_a(8'hF8);
    put_byte(OP_NOP);
    put_byte(OP_HLT);
    // Trap store behind HLT
    put_byte(OP_MOV_MEM_A);
    put_byte(8'hFA);
  endtask

  initial begin
    CLOCK = 1'b0;
    forever #2 CLOCK = ~CLOCK;
  end

  // Synchronous memory that answers 1 ns after sampling the bus
  initial begin : memory_model
    mem_ctrl_t  bus_ctrl;
    logic [7:0] bus_addr;
    logic [7:0] bus_data;
    logic       prev_write;
    read_bus    = 8'h00;
    store_count = 0;
    prev_write  = 1'b0;
    load_program();
    forever begin
      @(posedge CLOCK);
      bus_ctrl = ctrl_bus;
      bus_addr = addr_bus;
      bus_data = write_bus;
      #1;
      if (bus_ctrl == WRITE) begin
        mem[bus_addr] = bus_data;
        if (!prev_write) begin
          store_count++;
        end
      end
      if (bus_ctrl == READ) begin
        read_bus = mem[bus_addr];
      end
      prev_write = (bus_ctrl == WRITE);
    end
  end

  always @(posedge CLOCK) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      report_error($sformatf("timeout after %0d cycles", cycle));
    end
  end

  a_reset_ctrl_idle: assert property (
    @(posedge CLOCK) RESET && cycle != 0 |-> ctrl_bus == STAY
  ) else report_mismatch("ctrl_bus", 8'($sampled(ctrl_bus)), 8'(STAY));

  a_reset_write_bus_zero: assert property (
    @(posedge CLOCK) RESET && cycle != 0 |-> write_bus == 8'h00
  ) else report_mismatch("write_bus", $sampled(write_bus), 8'h00);

  a_write_address: assert property (
    @(posedge CLOCK) ctrl_bus == WRITE |-> exp_valid[addr_bus]
  ) else report_error($sformatf("write to unexpected address %02h", $sampled(addr_bus)));

  a_write_data: assert property (
    @(posedge CLOCK) ctrl_bus == WRITE && exp_valid[addr_bus] |-> write_bus == exp_data[addr_bus]
  ) else report_mismatch("write_bus", $sampled(write_bus), exp_data[$sampled(addr_bus)]);

  a_write_flags: assert property (
    @(posedge CLOCK) ctrl_bus == WRITE && exp_valid[addr_bus] |-> flags == exp_flags[addr_bus]
  ) else report_mismatch("flags", $sampled(flags), exp_flags[$sampled(addr_bus)]);

  a_skipped_value_absent: assert property (
    @(posedge CLOCK) ctrl_bus == WRITE |-> write_bus != SKIPPED_VALUE
  ) else report_error("value behind the jump was stored");

  a_halt_no_write: assert property (
    @(posedge CLOCK) halt_window |-> ctrl_bus != WRITE
  ) else report_error("memory write after HLT");

  a_halt_out_stable: assert property (
    @(posedge CLOCK) halt_window |-> out == model_a
  ) else report_mismatch("out", $sampled(out), model_a);

  initial begin
    RESET       = 1'b1;
    halt_window = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLOCK);
    #1 RESET = 1'b0;
    while (store_count < exp_store_count) begin
      @(posedge CLOCK);
    end
    // NOP and HLT still ahead once the last store is off the bus
    repeat (2) @(posedge CLOCK);
    #1 halt_window = 1'b1;
    repeat (HALT_ENTRY_CYCLES + HALT_HOLD_CYCLES) @(posedge CLOCK);
    if (store_count != exp_store_count) begin
      report_error($sformatf("saw %0d stores instead of %0d", store_count, exp_store_count));
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
